/* all.f */
logic/mo_cfg_pkg.sv
logic/mo_mem_pkg.sv
logic/credit_fifo.sv
logic/ioctl_router.sv
logic/rom_bank_packer.sv
logic/sdram_write_arbiter.sv
logic/mo_loader_top.sv
verification/mo_loader_tb.sv

/* logic/credit_fifo.sv */
`timescale 1ns/1ps

module credit_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk_sys,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     not_empty,
    output logic     credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        ptr_inc = (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign not_empty = (count != '0);
    assign do_pop    = pop && not_empty;   // pop on empty is ignored
    assign pop_data  = mem[rd_ptr];

    // overflow never happens as long as the sender respects its credits
    always_ff @(posedge clk_sys) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count  <= count + CNT_W'(push) - CNT_W'(do_pop);
            credit <= do_pop;   // one credit back per entry freed
        end
    end

endmodule

/* logic/ioctl_router.sv */
`timescale 1ns/1ps

module ioctl_router #(
    parameter int NUM_BANKS = mo_cfg_pkg::NUM_BANKS_DEF,
    parameter int DEPTH     = mo_cfg_pkg::BYTE_FIFO_DEPTH_DEF
) (
    input  logic                          clk_sys,
    input  logic                          rst_n,
    input  logic                          ioctl_download,
    input  logic [mo_cfg_pkg::IDX_W-1:0]  ioctl_index,
    input  logic                          ioctl_wr,
    input  logic [mo_cfg_pkg::ADDR_W-1:0] ioctl_addr,
    input  logic [mo_cfg_pkg::BYTE_W-1:0] ioctl_dout,
    output logic [NUM_BANKS-1:0]          byte_wr,
    output mo_mem_pkg::ioctl_byte_t       byte_data,
    input  logic [NUM_BANKS-1:0]          byte_credit,
    output logic [NUM_BANKS-1:0]          overflow,
    output logic                          download_end
);

    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [CNT_W-1:0]     credits [NUM_BANKS];
    logic [NUM_BANKS-1:0] send;
    logic [NUM_BANKS-1:0] drop;
    logic                 dl_q;

    // bank decode, bytes with index >= NUM_BANKS match nothing
    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            send[i] = 1'b0;
            drop[i] = 1'b0;
            if (ioctl_wr && ioctl_index == mo_cfg_pkg::IDX_W'(i)) begin
                send[i] = (credits[i] != '0);
                drop[i] = (credits[i] == '0);
            end
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_BANKS; i++) begin
                credits[i] <= CNT_W'(DEPTH);
            end
            byte_wr      <= '0;
            overflow     <= '0;
            dl_q         <= 1'b0;
            download_end <= 1'b0;
        end else begin
            for (int i = 0; i < NUM_BANKS; i++) begin
                credits[i] <= credits[i] - CNT_W'(send[i]) + CNT_W'(byte_credit[i]);
            end
            byte_wr      <= send;
            overflow     <= overflow | drop;   // sticky until reset
            dl_q         <= ioctl_download;
            download_end <= dl_q && !ioctl_download;
        end
    end

    // shared by all packers, qualified by byte_wr
    always_ff @(posedge clk_sys) begin
        if (ioctl_wr) begin
            byte_data.addr <= ioctl_addr;
            byte_data.data <= ioctl_dout;
        end
    end

endmodule

/* logic/mo_cfg_pkg.sv */
package mo_cfg_pkg;

    // banks are ROM, tape, cartridge and spare
    localparam int NUM_BANKS_DEF = 4;

    // byte buffer per packer, also the router's starting credit count
    localparam int BYTE_FIFO_DEPTH_DEF = 8;

    // memory writes allowed in flight at once
    localparam int MEM_CREDITS_DEF = 2;

    // word buffer inside each packer
    localparam int WORD_FIFO_DEPTH = 4;

    localparam int ADDR_W = 25;   // ioctl_addr width
    localparam int IDX_W  = 8;    // ioctl_index width
    localparam int BYTE_W = 8;    // ioctl_dout width

    // download index as sent by the configuration controller
    // an index of NUM_BANKS or above is not routed anywhere
    typedef enum logic [IDX_W-1:0] {
        IDX_ROM   = 8'd0,
        IDX_TAPE  = 8'd1,
        IDX_CART  = 8'd2,
        IDX_SPARE = 8'd3
    } dl_index_e;

endpackage

/* logic/mo_loader_top.sv */
`timescale 1ns/1ps

module mo_loader_top #(
    parameter int NUM_BANKS       = mo_cfg_pkg::NUM_BANKS_DEF,
    parameter int BYTE_FIFO_DEPTH = mo_cfg_pkg::BYTE_FIFO_DEPTH_DEF,
    parameter int MEM_CREDITS     = mo_cfg_pkg::MEM_CREDITS_DEF
) (
    input  logic                          clk_sys,
    input  logic                          rst_n,
    input  logic                          ioctl_download,
    input  logic [mo_cfg_pkg::IDX_W-1:0]  ioctl_index,
    input  logic                          ioctl_wr,
    input  logic [mo_cfg_pkg::ADDR_W-1:0] ioctl_addr,
    input  logic [mo_cfg_pkg::BYTE_W-1:0] ioctl_dout,
    input  logic                          mem_credit,
    output logic                          mem_wr,
    output mo_mem_pkg::mem_word_t         mem_req,
    output logic                          core_reset,
    output logic [NUM_BANKS-1:0]          overflow
);

    logic [NUM_BANKS-1:0]    byte_wr;
    logic [NUM_BANKS-1:0]    byte_credit;
    mo_mem_pkg::ioctl_byte_t byte_data;
    logic                    download_end;
    logic [NUM_BANKS-1:0]    word_req;
    logic [NUM_BANKS-1:0]    word_gnt;
    mo_mem_pkg::mem_word_t   word_data [NUM_BANKS];
    logic [NUM_BANKS-1:0]    busy;
    logic                    idle;

    ioctl_router #(
        .NUM_BANKS (NUM_BANKS),
        .DEPTH     (BYTE_FIFO_DEPTH)
    ) u_router (
        .clk_sys        (clk_sys),
        .rst_n          (rst_n),
        .ioctl_download (ioctl_download),
        .ioctl_index    (ioctl_index),
        .ioctl_wr       (ioctl_wr),
        .ioctl_addr     (ioctl_addr),
        .ioctl_dout     (ioctl_dout),
        .byte_wr        (byte_wr),
        .byte_data      (byte_data),
        .byte_credit    (byte_credit),
        .overflow       (overflow),
        .download_end   (download_end)
    );

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        rom_bank_packer #(
            .BANK  (i),
            .DEPTH (BYTE_FIFO_DEPTH)
        ) u_packer (
            .clk_sys      (clk_sys),
            .rst_n        (rst_n),
            .byte_wr      (byte_wr[i]),
            .byte_data    (byte_data),
            .download_end (download_end),
            .byte_credit  (byte_credit[i]),
            .word_req     (word_req[i]),
            .word_data    (word_data[i]),
            .word_gnt     (word_gnt[i]),
            .busy         (busy[i])
        );
    end

    sdram_write_arbiter #(
        .NUM_BANKS   (NUM_BANKS),
        .MEM_CREDITS (MEM_CREDITS)
    ) u_arbiter (
        .clk_sys    (clk_sys),
        .rst_n      (rst_n),
        .word_req   (word_req),
        .word_data  (word_data),
        .word_gnt   (word_gnt),
        .mem_wr     (mem_wr),
        .mem_req    (mem_req),
        .mem_credit (mem_credit),
        .idle       (idle)
    );

    // core stays in reset until the whole download has reached memory
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            core_reset <= 1'b1;
        end else begin
            core_reset <= ioctl_download || (|busy) || !idle;
        end
    end

endmodule

/* logic/mo_mem_pkg.sv */
package mo_mem_pkg;

    localparam int BANK_W  = 2;
    localparam int WADDR_W = mo_cfg_pkg::ADDR_W - 1;   // word address, byte address / 2
    localparam int WDATA_W = 2 * mo_cfg_pkg::BYTE_W;
    localparam int MASK_W  = 2;

    // byte masks for one 16 bit word
    localparam logic [MASK_W-1:0] MASK_LO   = 2'b01;   // even byte only
    localparam logic [MASK_W-1:0] MASK_HI   = 2'b10;   // odd byte only
    localparam logic [MASK_W-1:0] MASK_BOTH = 2'b11;

    // one downloaded byte from the ioctl bus
    typedef struct packed {
        logic [mo_cfg_pkg::ADDR_W-1:0] addr;
        logic [mo_cfg_pkg::BYTE_W-1:0] data;
    } ioctl_byte_t;

    // one SDRAM write word
    // data[7:0] is the even address byte, covered by mask[0]
    typedef struct packed {
        logic [BANK_W-1:0]  bank;
        logic [WADDR_W-1:0] addr;
        logic [WDATA_W-1:0] data;
        logic [MASK_W-1:0]  mask;
    } mem_word_t;

endpackage

/* logic/rom_bank_packer.sv */
`timescale 1ns/1ps

module rom_bank_packer #(
    parameter int BANK  = 0,
    parameter int DEPTH = mo_cfg_pkg::BYTE_FIFO_DEPTH_DEF
) (
    input  logic                    clk_sys,
    input  logic                    rst_n,
    input  logic                    byte_wr,
    input  mo_mem_pkg::ioctl_byte_t byte_data,
    input  logic                    download_end,
    output logic                    byte_credit,
    output logic                    word_req,
    output mo_mem_pkg::mem_word_t   word_data,
    input  logic                    word_gnt,
    output logic                    busy
);

    localparam int AW      = mo_cfg_pkg::ADDR_W;
    localparam int WDEPTH  = mo_cfg_pkg::WORD_FIFO_DEPTH;
    localparam int WCRED_W = $clog2(WDEPTH + 1);

    mo_mem_pkg::ioctl_byte_t cur;
    mo_mem_pkg::ioctl_byte_t held;
    mo_mem_pkg::mem_word_t   nxt_word;
    mo_mem_pkg::mem_word_t   word_reg;
    logic                    held_v;
    logic                    held_set;
    logic                    held_clr;
    logic                    end_pend;
    logic                    byte_avail;
    logic                    byte_pop;
    logic                    emit;
    logic                    room;
    logic                    word_push;
    logic                    word_cr;
    logic [WCRED_W-1:0]      wcred;

    credit_fifo #(
        .payload_t (mo_mem_pkg::ioctl_byte_t),
        .DEPTH     (DEPTH)
    ) u_byte_fifo (
        .clk_sys   (clk_sys),
        .rst_n     (rst_n),
        .push      (byte_wr),
        .push_data (byte_data),
        .pop       (byte_pop),
        .pop_data  (cur),
        .not_empty (byte_avail),
        .credit    (byte_credit)
    );

    credit_fifo #(
        .payload_t (mo_mem_pkg::mem_word_t),
        .DEPTH     (WDEPTH)
    ) u_word_fifo (
        .clk_sys   (clk_sys),
        .rst_n     (rst_n),
        .push      (word_push),
        .push_data (word_reg),
        .pop       (word_gnt),
        .pop_data  (word_data),
        .not_empty (word_req),
        .credit    (word_cr)
    );

    assign room = (wcred != '0);   // free slot in the word FIFO

    // at most one word per cycle, a broken pair flushes first and
    // leaves the new byte in the FIFO for the next cycle
    always_comb begin
        byte_pop      = 1'b0;
        emit          = 1'b0;
        held_set      = 1'b0;
        held_clr      = 1'b0;
        nxt_word.bank = mo_mem_pkg::BANK_W'(BANK);
        nxt_word.addr = held.addr[AW-1:1];
        nxt_word.data = {8'h00, held.data};
        nxt_word.mask = mo_mem_pkg::MASK_LO;
        if (byte_avail) begin
            if (held_v) begin
                if (room) begin
                    emit     = 1'b1;
                    held_clr = 1'b1;
                    if (cur.addr == {held.addr[AW-1:1], 1'b1}) begin
                        byte_pop      = 1'b1;
                        nxt_word.data = {cur.data, held.data};
                        nxt_word.mask = mo_mem_pkg::MASK_BOTH;
                    end
                end
            end else if (!cur.addr[0]) begin
                byte_pop = 1'b1;   // even byte waits for its partner
                held_set = 1'b1;
            end else if (room) begin
                emit          = 1'b1;
                byte_pop      = 1'b1;
                nxt_word.addr = cur.addr[AW-1:1];
                nxt_word.data = {cur.data, 8'h00};
                nxt_word.mask = mo_mem_pkg::MASK_HI;
            end
        end else if (held_v && end_pend && room) begin
            emit     = 1'b1;
            held_clr = 1'b1;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            held_v    <= 1'b0;
            end_pend  <= 1'b0;
            word_push <= 1'b0;
            wcred     <= WCRED_W'(WDEPTH);
        end else begin
            if (held_set) begin
                held_v <= 1'b1;
            end else if (held_clr) begin
                held_v <= 1'b0;
            end
            // end of download waits until the byte FIFO has drained
            if (download_end) begin
                end_pend <= 1'b1;
            end else if (!byte_avail && !held_v) begin
                end_pend <= 1'b0;
            end
            word_push <= emit;
            wcred     <= wcred - WCRED_W'(emit) + WCRED_W'(word_cr);
        end
    end

    always_ff @(posedge clk_sys) begin
        if (held_set) begin
            held <= cur;
        end
        word_reg <= nxt_word;
    end

    assign busy = byte_wr || byte_avail || held_v || word_push || word_req;

endmodule

/* logic/sdram_write_arbiter.sv */
`timescale 1ns/1ps

module sdram_write_arbiter #(
    parameter int NUM_BANKS   = mo_cfg_pkg::NUM_BANKS_DEF,
    parameter int MEM_CREDITS = mo_cfg_pkg::MEM_CREDITS_DEF
) (
    input  logic                  clk_sys,
    input  logic                  rst_n,
    input  logic [NUM_BANKS-1:0]  word_req,
    input  mo_mem_pkg::mem_word_t word_data [NUM_BANKS],
    output logic [NUM_BANKS-1:0]  word_gnt,
    output logic                  mem_wr,
    output mo_mem_pkg::mem_word_t mem_req,
    input  logic                  mem_credit,
    output logic                  idle
);

    localparam int SEL_W  = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;
    localparam int CRED_W = $clog2(MEM_CREDITS + 1);

    logic [SEL_W-1:0]  last;
    logic [SEL_W-1:0]  sel;
    logic              found;
    logic              gnt_any;
    logic [CRED_W-1:0] cred;

    // round robin, search starts one past the last winner
    always_comb begin
        int idx;
        found = 1'b0;
        sel   = '0;
        for (int k = 1; k <= NUM_BANKS; k++) begin
            idx = (int'(last) + k) % NUM_BANKS;
            if (!found && word_req[idx]) begin
                found = 1'b1;
                sel   = SEL_W'(idx);
            end
        end
    end

    assign gnt_any = found && (cred != '0);   // hold off without memory credit

    always_comb begin
        word_gnt = '0;
        if (gnt_any) begin
            word_gnt[sel] = 1'b1;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            last   <= SEL_W'(NUM_BANKS - 1);   // bank 0 wins first
            cred   <= CRED_W'(MEM_CREDITS);
            mem_wr <= 1'b0;
        end else begin
            if (gnt_any) begin
                last <= sel;
            end
            cred   <= cred - CRED_W'(gnt_any) + CRED_W'(mem_credit);
            mem_wr <= gnt_any;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (gnt_any) begin
            mem_req <= word_data[sel];
        end
    end

    assign idle = (cred == CRED_W'(MEM_CREDITS)) && !mem_wr;

endmodule

/* run.sh */
#!/bin/sh
# compile and run the loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module mo_loader_tb \
    --Mdir obj_dir -o mo_loader_sim \
    -f all.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/mo_loader_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx 'Finished with no errors'; then
    exit 0
fi
exit 1

/* verification/loader_tests.txt */
# t name | d index addr byte count | e | c mode (0 random credit delay, 1 stall until sent)
# w bank word_addr data mask count | o overflow_bits, all hex, runs step data by 1 or 0202
t even_stream
d 0 100 10 8
e
c 0
w 0 80 1110 3 4
o 0
t odd_edges
d 1 201 21 6
d 1 300 40 1
d 1 309 50 1
e
c 0
w 1 100 2100 2 1
w 1 101 2322 3 2
w 1 103 0026 1 1
w 1 180 0040 1 1
w 1 184 5000 2 1
o 0
t interleave
d 0 0 a0 1
d 2 40 c0 1
d 0 1 a1 1
d 5 0 ee 1
d 2 41 c1 1
d ff 10 ee 1
d 3 7 d7 1
d 0 2 a2 1
e
c 0
w 0 0 a1a0 3 1
w 2 20 c1c0 3 1
w 3 3 d700 2 1
w 0 1 00a2 1 1
o 0
t stall_overflow
d 2 0 0 18
e
c 1
w 2 0 0100 3 a
w 2 a 0014 1 1
o 4

/* verification/mo_loader_tb.sv */
`timescale 1ns/1ps

module mo_loader_tb;

    localparam int NUM_BANKS   = mo_cfg_pkg::NUM_BANKS_DEF;
    localparam int FIFO_DEPTH  = mo_cfg_pkg::BYTE_FIFO_DEPTH_DEF;
    localparam int MEM_CREDITS = mo_cfg_pkg::MEM_CREDITS_DEF;
    localparam int TIMEOUT     = 2000;   // cycles allowed per wait

    logic                          clk_sys;
    logic                          rst_n;
    logic                          ioctl_download;
    logic [mo_cfg_pkg::IDX_W-1:0]  ioctl_index;
    logic                          ioctl_wr;
    logic [mo_cfg_pkg::ADDR_W-1:0] ioctl_addr;
    logic [mo_cfg_pkg::BYTE_W-1:0] ioctl_dout;
    logic                          mem_credit;
    logic                          mem_wr;
    mo_mem_pkg::mem_word_t         mem_req;
    logic                          core_reset;
    logic [NUM_BANKS-1:0]          overflow;

    mo_mem_pkg::ioctl_byte_t stim_q[$];
    logic [7:0]              stim_idx_q[$];   // download index per byte
    mo_mem_pkg::mem_word_t   exp_q[$];
    mo_mem_pkg::mem_word_t   got_q[$];
    int                      due_q[$];        // cycle at which each credit goes back
    int                      cycle;
    int                      errors;
    int                      test_errors;
    int                      tests_run;
    int                      tests_failed;
    logic                    hold_credits;
    logic                    give_credit;
    logic                    watch;
    logic [31:0]             rng;

    mo_loader_top #(
        .NUM_BANKS       (NUM_BANKS),
        .BYTE_FIFO_DEPTH (FIFO_DEPTH),
        .MEM_CREDITS     (MEM_CREDITS)
    ) UUT (
        .clk_sys        (clk_sys),
        .rst_n          (rst_n),
        .ioctl_download (ioctl_download),
        .ioctl_index    (ioctl_index),
        .ioctl_wr       (ioctl_wr),
        .ioctl_addr     (ioctl_addr),
        .ioctl_dout     (ioctl_dout),
        .mem_credit     (mem_credit),
        .mem_wr         (mem_wr),
        .mem_req        (mem_req),
        .core_reset     (core_reset),
        .overflow       (overflow)
    );

    initial begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;
    end

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // memory model records writes and hands credits back after a delay
    always @(negedge clk_sys) begin
        if (!rst_n) begin
            due_q.delete();
            give_credit = 1'b0;
        end else begin
            if (mem_wr) begin
                got_q.push_back(mem_req);
                rng = next_rand(rng);
                due_q.push_back(cycle + 1 + int'(rng % 32'd6));
            end
            give_credit = 1'b0;
            if (!hold_credits && due_q.size() > 0 && due_q[0] <= cycle) begin
                void'(due_q.pop_front());
                give_credit = 1'b1;
            end
            if (watch) begin
                assert (core_reset || !(ioctl_download || got_q.size() < exp_q.size()))
                else begin
                    $display("core_reset low at cycle %0d with the download unfinished", cycle);
                    test_errors++;
                end
            end
        end
    end

    always @(posedge clk_sys) begin
        cycle      <= cycle + 1;
        mem_credit <= give_credit;
    end

    task automatic reset_dut();
        @(posedge clk_sys);
        rst_n <= 1'b0;
        repeat (4) @(posedge clk_sys);
        rst_n <= 1'b1;
        got_q.delete();
    endtask

    task automatic send_byte(input logic [7:0] idx, input mo_mem_pkg::ioctl_byte_t b);
        @(posedge clk_sys);
        ioctl_wr    <= 1'b1;
        ioctl_index <= idx;
        ioctl_addr  <= b.addr;
        ioctl_dout  <= b.data;
        @(posedge clk_sys);
        ioctl_wr    <= 1'b0;   // one idle cycle between bytes
    endtask

    task automatic wait_writes();
        int n;
        n = 0;
        while (got_q.size() < exp_q.size() && n < TIMEOUT) begin
            @(posedge clk_sys);
            n++;
        end
        assert (got_q.size() >= exp_q.size()) else begin
            $display("timeout with %0d of %0d writes seen", got_q.size(), exp_q.size());
            test_errors++;
        end
    endtask

    task automatic wait_core_reset_low();
        int n;
        n = 0;
        @(negedge clk_sys);
        while (core_reset && n < TIMEOUT) begin
            @(negedge clk_sys);
            n++;
        end
        assert (!core_reset) else begin
            $display("timeout with core_reset still high after %0d cycles", TIMEOUT);
            test_errors++;
        end
    endtask

    // order only holds within one bank
    task automatic compare_writes();
        int j;
        assert (got_q.size() == exp_q.size()) else begin
            $display("expected %0d writes but saw %0d", exp_q.size(), got_q.size());
            test_errors++;
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            j = 0;
            for (int i = 0; i < exp_q.size(); i++) begin
                if (int'(exp_q[i].bank) == b) begin
                    while (j < got_q.size() && int'(got_q[j].bank) != b) begin
                        j++;
                    end
                    assert (j < got_q.size()) else begin
                        $display("bank %0d never wrote word address %h", b, exp_q[i].addr);
                        test_errors++;
                    end
                    if (j < got_q.size()) begin
                        assert (got_q[j] == exp_q[i]) else begin
                            $display("FAILED mem_req bank %0d: got %h, expected %h",
                                     b, got_q[j], exp_q[i]);
                            test_errors++;
                        end
                        j++;
                    end
                end
            end
        end
    endtask

    task automatic run_test(input string name, input int mode,
                            input logic [NUM_BANKS-1:0] exp_ovf);
        test_errors  = 0;
        reset_dut();
        hold_credits = (mode == 1);
        wait_core_reset_low();
        @(posedge clk_sys);
        ioctl_download <= 1'b1;
        @(posedge clk_sys);
        watch = 1'b1;
        @(negedge clk_sys);
        assert (core_reset) else begin
            $display("core_reset did not rise with ioctl_download");
            test_errors++;
        end
        for (int i = 0; i < stim_q.size(); i++) begin
            send_byte(stim_idx_q[i], stim_q[i]);
        end
        repeat (4) @(posedge clk_sys);
        ioctl_download <= 1'b0;
        hold_credits = 1'b0;   // stalled memory wakes up here
        wait_writes();
        wait_core_reset_low();
        @(posedge clk_sys);
        watch = 1'b0;
        @(negedge clk_sys);
        compare_writes();
        assert (overflow == exp_ovf) else begin
            $display("FAILED overflow: got %h, expected %h", overflow, exp_ovf);
            test_errors++;
        end
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        errors += test_errors;
        $display("test %0s: %0s, %0d errors", name, (test_errors == 0) ? "passed" : "failed",
                 test_errors);
        stim_q.delete();
        stim_idx_q.delete();
        exp_q.delete();
    endtask

    task automatic read_tests(input int fd);
        string                   line;
        string                   name;
        int                      n;
        int                      mode;
        logic [31:0]             a;
        logic [31:0]             b;
        logic [31:0]             c;
        logic [31:0]             d;
        logic [31:0]             e;
        logic [31:0]             sum;
        mo_mem_pkg::ioctl_byte_t sb;
        mo_mem_pkg::mem_word_t   ew;
        name = "unnamed";
        mode = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            case (line[0])
                "t": name = line.substr(2, line.len() - 2);
                "d": begin
                    n = $sscanf(line, "d %h %h %h %h", a, b, c, d);
                    for (int k = 0; k < int'(d); k++) begin
                        sum     = b + k;
                        sb.addr = sum[mo_cfg_pkg::ADDR_W-1:0];
                        sum     = c + k;
                        sb.data = sum[7:0];
                        stim_idx_q.push_back(a[7:0]);
                        stim_q.push_back(sb);
                    end
                end
                "c": begin
                    n    = $sscanf(line, "c %h", a);
                    mode = int'(a);
                end
                "w": begin
                    n = $sscanf(line, "w %h %h %h %h %h", a, b, c, d, e);
                    for (int k = 0; k < int'(e); k++) begin
                        ew.bank = a[1:0];
                        sum     = b + k;
                        ew.addr = sum[mo_mem_pkg::WADDR_W-1:0];
                        sum     = c + k * 32'h0202;   // next byte pair
                        ew.data = sum[15:0];
                        ew.mask = d[1:0];
                        exp_q.push_back(ew);
                    end
                end
                "o": begin
                    n = $sscanf(line, "o %h", a);
                    run_test(name, mode, a[NUM_BANKS-1:0]);
                end
                default: ;   // comment lines, blank lines and the e marker
            endcase
        end
    endtask

    initial begin
        int fd;
        rst_n          = 1'b0;
        ioctl_download = 1'b0;
        ioctl_index    = '0;
        ioctl_wr       = 1'b0;
        ioctl_addr     = '0;
        ioctl_dout     = '0;
        mem_credit     = 1'b0;
        cycle          = 0;
        errors         = 0;
        test_errors    = 0;
        tests_run      = 0;
        tests_failed   = 0;
        hold_credits   = 1'b0;
        give_credit    = 1'b0;
        watch          = 1'b0;
        rng            = 32'd55195;
        fd = $fopen("verification/loader_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/loader_tests.txt");
            errors++;
        end else begin
            read_tests(fd);
            $fclose(fd);
        end
        assert (tests_run != 0) else begin
            $display("no test was run");
            errors++;
        end
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
